/* axis_weight_rotator.sv */
// slave beats must be output width; one header beat then weights per layer, tlast on the last
`default_nettype none

module axis_weight_rotator (
  input  wire logic                   aclk,
  input  wire logic                   i_rst_n,
  input  wire logic                   i_s_tvalid,
  output logic                        o_s_tready,
  input  wire weight_rot_pkg::beat_t  i_s_tdata,
  input  wire logic                   i_s_tlast,
  output logic                        o_m_tvalid,
  input  wire logic                   i_m_tready,
  output weight_rot_pkg::beat_t       o_m_tdata,
  output logic                        o_m_tlast,
  output weight_rot_pkg::tuser_t      o_m_tuser
);

  import weight_rot_pkg::*;

  logic [1:0]        done_read;
  logic [1:0]        done_write;
  hdr_t [1:0]        hdr;
  logic [1:0]        bank_wen;
  logic [1:0]        bank_clear;
  beat_t             wdata;
  logic [1:0]        bank_ren;
  logic [1:0]        bank_rewind;
  beat_t [1:0]       rdata;

  weight_writer writer_i (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_s_tvalid   (i_s_tvalid),
    .o_s_tready   (o_s_tready),
    .i_s_tdata    (i_s_tdata),
    .i_s_tlast    (i_s_tlast),
    .i_done_read  (done_read),
    .o_done_write (done_write),
    .o_hdr        (hdr),
    .o_bank_wen   (bank_wen),
    .o_bank_clear (bank_clear),
    .o_wdata      (wdata)
  );

  // ping-pong pair
  for (genvar b = 0; b < 2; b++) begin : g_bank
    weight_bank bank_i (
      .aclk       (aclk),
      .i_rst_n    (i_rst_n),
      .i_clear    (bank_clear[b]),
      .i_wen      (bank_wen[b]),
      .i_wdata    (wdata),
      .i_ren      (bank_ren[b]),
      .i_rewind   (bank_rewind[b]),
      .i_addr_max (hdr[b].addr_max),
      .o_rdata    (rdata[b])
    );
  end

  weight_reader reader_i (
    .aclk          (aclk),
    .i_rst_n       (i_rst_n),
    .i_done_write  (done_write),
    .o_done_read   (done_read),
    .i_hdr         (hdr),
    .o_bank_ren    (bank_ren),
    .o_bank_rewind (bank_rewind),
    .i_rdata       (rdata),
    .o_m_tvalid    (o_m_tvalid),
    .i_m_tready    (i_m_tready),
    .o_m_tdata     (o_m_tdata),
    .o_m_tlast     (o_m_tlast),
    .o_m_tuser     (o_m_tuser)
  );

endmodule

`default_nettype wire

/* list.f */
weight_rot_pkg.sv
weight_bank.sv
weight_writer.sv
rotation_counters.sv
weight_reader.sv
axis_weight_rotator.sv
weight_rotator_asserts.sv
tb_weight_rotator.sv

/* rotation_counters.sv */
// i_hdr must stay stable from i_load until the last step of the layer
`default_nettype none

module rotation_counters (
  input  wire logic                  aclk,
  input  wire logic                  i_rst_n,
  input  wire weight_rot_pkg::hdr_t  i_hdr,
  input  wire logic                  i_load,
  input  wire logic                  i_step,
  output logic                       o_last,
  output weight_rot_pkg::tuser_t     o_user
);

  import weight_rot_pkg::*;

  logic [KH_W-1:0]     kh_start;
  logic [KH_W-1:0]     cnt_kh;
  logic [CIN_W-1:0]    cnt_cin;
  logic [COLS_W-1:0]   cnt_cols;
  logic [BLOCKS_W-1:0] cnt_blocks;
  logic                last_kh;
  logic                last_cin;
  logic                last_cols;
  logic                last_blocks;

  assign kh_start = {i_hdr.kh2, 1'b0}; // kernel rows minus one

  // down-counters, order kh -> cin -> cols -> blocks
  // last flags registered alongside so they track the count
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_kh      <= '0;
      cnt_cin     <= '0;
      cnt_cols    <= '0;
      cnt_blocks  <= '0;
      last_kh     <= 1'b0;
      last_cin    <= 1'b0;
      last_cols   <= 1'b0;
      last_blocks <= 1'b0;
    end else if (i_load) begin
      cnt_kh      <= kh_start;
      cnt_cin     <= i_hdr.cin_1;
      cnt_cols    <= i_hdr.cols_1;
      cnt_blocks  <= i_hdr.blocks_1;
      last_kh     <= (kh_start == '0);
      last_cin    <= (i_hdr.cin_1 == '0);
      last_cols   <= (i_hdr.cols_1 == '0);
      last_blocks <= (i_hdr.blocks_1 == '0);
    end else if (i_step) begin
      cnt_kh  <= last_kh ? kh_start : cnt_kh - 1'b1;
      last_kh <= last_kh ? (kh_start == '0) : (cnt_kh == KH_W'(1));
      if (last_kh) begin
        cnt_cin  <= last_cin ? i_hdr.cin_1 : cnt_cin - 1'b1;
        last_cin <= last_cin ? (i_hdr.cin_1 == '0) : (cnt_cin == CIN_W'(1));
        if (last_cin) begin
          cnt_cols  <= last_cols ? i_hdr.cols_1 : cnt_cols - 1'b1;
          last_cols <= last_cols ? (i_hdr.cols_1 == '0) : (cnt_cols == COLS_W'(1));
          if (last_cols) begin
            cnt_blocks  <= last_blocks ? i_hdr.blocks_1 : cnt_blocks - 1'b1;
            last_blocks <= last_blocks ? (i_hdr.blocks_1 == '0)
                                       : (cnt_blocks == BLOCKS_W'(1));
          end
        end
      end
    end
  end

  assign o_last = last_kh && last_cin && last_cols && last_blocks;

  assign o_user.kw2          = i_hdr.kw2;
  assign o_user.is_w_first   = (cnt_kh == kh_start) && (cnt_cin == i_hdr.cin_1)
                               && (cnt_cols == i_hdr.cols_1);
  assign o_user.is_cin_last  = last_kh && last_cin;
  assign o_user.is_col_1_k2  = (cnt_cols == COLS_W'(i_hdr.kw2)); // col index cols-1-kw2
  assign o_user.is_top_block = (cnt_blocks == i_hdr.blocks_1);
  assign o_user.is_bot_block = last_blocks;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_weight_rotator -f list.f

out=$(./obj_dir/Vtb_weight_rotator 2>&1 || true)
printf '%s\n' "$out"

# pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "TB PASSED"

/* tb_weight_rotator.sv */
// directed tests; every layer keeps (2*kh2+1)*(cin_1+1) weight beats within one 64-beat bank
`default_nettype none

module tb_weight_rotator;

  timeunit 1ns;
  timeprecision 1ps;

  import weight_rot_pkg::*;

  logic        aclk;
  logic        i_rst_n;
  logic        i_s_tvalid;
  logic        o_s_tready;
  beat_t       i_s_tdata;
  logic        i_s_tlast;
  logic        o_m_tvalid;
  logic        i_m_tready;
  beat_t       o_m_tdata;
  logic        o_m_tlast;
  tuser_t      o_m_tuser;

  hdr_t        layers [8];
  beat_t       wts [8][BANK_DEPTH];
  string       test_name;
  bit          random_ready;
  int          layers_out;     // layers fully received
  int unsigned limit;
  int unsigned cycles;

  axis_weight_rotator dut_i (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tuser  (o_m_tuser)
  );

  bind axis_weight_rotator weight_rotator_asserts asserts_i (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tuser  (o_m_tuser)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_beat(input string what, input beat_t exp, input beat_t act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_user(input string what, input tuser_t exp, input tuser_t act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_last(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_ready(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  function automatic hdr_t make_hdr(input int kh2, input int kw2, input int cin_1,
                                    input int cols_1, input int blocks_1);
    hdr_t h;
    h.kh2      = KH2_W'(kh2);
    h.kw2      = KW2_W'(kw2);
    h.cin_1    = CIN_W'(cin_1);
    h.cols_1   = COLS_W'(cols_1);
    h.blocks_1 = BLOCKS_W'(blocks_1);
    h.addr_max = ADDR_W'((2 * kh2 + 1) * (cin_1 + 1) - 1); // one beat per kernel row and channel
    return h;
  endfunction

  function automatic int out_beats(input hdr_t h);
    return (2 * int'(h.kh2) + 1) * (int'(h.cin_1) + 1)
           * (int'(h.cols_1) + 1) * (int'(h.blocks_1) + 1);
  endfunction

  // position n split into mixed-radix digits, each counting down from its start
  function automatic void model_beat(input hdr_t h, input int n, output tuser_t u,
                                     output logic last);
    int kh;
    int cin;
    int cols;
    int blocks;
    int q;
    kh     = 2 * int'(h.kh2) - n % (2 * int'(h.kh2) + 1);
    q      = n / (2 * int'(h.kh2) + 1);
    cin    = int'(h.cin_1) - q % (int'(h.cin_1) + 1);
    q      = q / (int'(h.cin_1) + 1);
    cols   = int'(h.cols_1) - q % (int'(h.cols_1) + 1);
    q      = q / (int'(h.cols_1) + 1);
    blocks = int'(h.blocks_1) - q % (int'(h.blocks_1) + 1);
    u.kw2          = h.kw2;
    u.is_w_first   = (kh == 2 * int'(h.kh2)) && (cin == int'(h.cin_1))
                     && (cols == int'(h.cols_1));
    u.is_cin_last  = (kh == 0) && (cin == 0);
    u.is_col_1_k2  = (cols == int'(h.kw2));
    u.is_top_block = (blocks == int'(h.blocks_1));
    u.is_bot_block = (blocks == 0);
    last = (kh == 0) && (cin == 0) && (cols == 0) && (blocks == 0);
  endfunction

  task automatic setup_layers();
    layers[0] = make_hdr(0, 0, 2, 1, 1);
    layers[1] = make_hdr(1, 1, 1, 2, 0);
    layers[2] = layers[1];              // same layer again under back-pressure
    layers[3] = make_hdr(1, 0, 0, 1, 2);
    layers[4] = make_hdr(0, 2, 4, 3, 1);
    layers[5] = make_hdr(2, 1, 3, 1, 1);
    layers[6] = make_hdr(1, 2, 2, 2, 0);
    layers[7] = make_hdr(3, 0, 7, 0, 0);
    limit = 200;
    for (int l = 0; l < 8; l++) begin
      for (int i = 0; i < BANK_DEPTH; i++) begin
        if (l == 2) wts[l][i] = wts[1][i];
        else wts[l][i] = $urandom;
      end
      limit += 20 * (2 + int'(layers[l].addr_max) + out_beats(layers[l]));
    end
  endtask

  task automatic send_layer(input int li);
    int nwt;
    nwt = int'(layers[li].addr_max) + 1;
    for (int i = 0; i <= nwt; i++) begin
      @(negedge aclk);
      i_s_tvalid = 1'b1;
      i_s_tdata  = (i == 0) ? beat_t'(layers[li]) : wts[li][i-1];
      i_s_tlast  = (i == nwt);
      while (!o_s_tready) @(negedge aclk); // handshake at the next rising edge
    end
    @(negedge aclk);
    i_s_tvalid = 1'b0;
    i_s_tlast  = 1'b0;
  endtask

  task automatic expect_layer(input int li);
    tuser_t exp_user;
    logic   exp_last;
    int     n;
    int     nwt;
    n   = 0;
    nwt = int'(layers[li].addr_max) + 1;
    while (n < out_beats(layers[li])) begin
      @(negedge aclk);
      i_m_tready = random_ready ? 1'($urandom % 2) : 1'b1;
      if (o_m_tvalid && i_m_tready) begin
        model_beat(layers[li], n, exp_user, exp_last);
        check_beat($sformatf("layer %0d beat %0d data", li, n), wts[li][n % nwt], o_m_tdata);
        check_user($sformatf("layer %0d beat %0d tuser", li, n), exp_user, o_m_tuser);
        check_last($sformatf("layer %0d beat %0d tlast", li, n), exp_last, o_m_tlast);
        n++;
      end
    end
    layers_out++;
  endtask

  task automatic stream_layers(input int first, input int count);
    fork
      for (int l = first; l < first + count; l++) send_layer(l);
      for (int l = first; l < first + count; l++) expect_layer(l);
    join
  endtask

  // slave ready stays low in reset and comes up one cycle after release
  task automatic test_reset_ready();
    test_name = "reset_ready";
    repeat (2) @(negedge aclk);
    check_ready("s_tready in reset", 1'b0, o_s_tready);
    i_rst_n = 1'b1;
    @(negedge aclk);
    check_ready("s_tready one cycle after reset", 1'b1, o_s_tready);
  endtask

  task automatic test_repeat_order();
    test_name    = "repeat_order";
    random_ready = 1'b0;
    stream_layers(0, 1);
  endtask

  task automatic test_flags();
    test_name    = "flags";
    random_ready = 1'b0;
    stream_layers(1, 1);
  endtask

  task automatic test_flags_backpressure();
    test_name    = "flags_backpressure";
    random_ready = 1'b1;
    stream_layers(2, 1);
  endtask

  task automatic test_back_to_back();
    int base;
    test_name    = "back_to_back";
    random_ready = 1'b0;
    base         = layers_out;
    fork
      begin
        send_layer(3);
        send_layer(4);
        if (layers_out != base) begin
          $display("second layer was still waiting after the first one had streamed");
          stop_with_failure();
        end
      end
      begin
        expect_layer(3);
        expect_layer(4);
      end
    join
  endtask

  task automatic test_bank_cycling();
    test_name    = "bank_cycling";
    random_ready = 1'b1;
    stream_layers(5, 3);
  endtask

  initial begin
    cycles = 0;
    @(posedge i_rst_n);
    forever begin
      @(posedge aclk);
      cycles++;
      if (cycles > limit) begin
        $display("timeout: the tests did not finish within %0d cycles", limit);
        stop_with_failure();
      end
    end
  end

  initial begin
    i_rst_n    = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tlast  = 1'b0;
    i_m_tready = 1'b0;
    layers_out = 0;
    void'($urandom(93343));
    setup_layers();
    test_reset_ready();
    test_repeat_order();
    test_flags();
    test_flags_backpressure();
    test_back_to_back();
    test_bank_cycling();
    @(negedge aclk);
    i_m_tready = 1'b0;     // any stray beat now stays visible
    repeat (10) @(negedge aclk);
    if (o_m_tvalid) begin
      $display("output beat appeared after the last layer had been received");
      stop_with_failure();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* weight_bank.sv */
// read data valid exactly one cycle after i_ren; reads and writes of one bank never overlap
`default_nettype none

module weight_bank (
  input  wire logic                           aclk,
  input  wire logic                           i_rst_n,
  input  wire logic                           i_clear,
  input  wire logic                           i_wen,
  input  wire weight_rot_pkg::beat_t          i_wdata,
  input  wire logic                           i_ren,
  input  wire logic                           i_rewind,
  input  wire logic [weight_rot_pkg::ADDR_W-1:0] i_addr_max,
  output weight_rot_pkg::beat_t               o_rdata
);

  import weight_rot_pkg::*;

  beat_t             mem [BANK_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_clear) begin
        wr_ptr <= '0;
      end else if (i_wen) begin
        wr_ptr <= wr_ptr + 1'b1;
      end

      if (i_clear || i_rewind) begin
        rd_ptr <= '0;
      end else if (i_ren) begin
        rd_ptr <= (rd_ptr == i_addr_max) ? '0 : rd_ptr + 1'b1; // cyclic over the layer
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wen) begin
      mem[wr_ptr] <= i_wdata;
    end
    if (i_ren) begin
      o_rdata <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* weight_reader.sv */
// bank read latency must be one cycle; up to two reads in flight, extras dropped on switch
`default_nettype none

module weight_reader (
  input  wire logic                        aclk,
  input  wire logic                        i_rst_n,
  input  wire logic [1:0]                  i_done_write,
  output logic [1:0]                       o_done_read,
  input  wire weight_rot_pkg::hdr_t [1:0]  i_hdr,
  output logic [1:0]                       o_bank_ren,
  output logic [1:0]                       o_bank_rewind,
  input  wire weight_rot_pkg::beat_t [1:0] i_rdata,
  output logic                             o_m_tvalid,
  input  wire logic                        i_m_tready,
  output weight_rot_pkg::beat_t            o_m_tdata,
  output logic                             o_m_tlast,
  output weight_rot_pkg::tuser_t           o_m_tuser
);

  import weight_rot_pkg::*;

  r_state_e   r_state;
  r_state_e   r_state_next;
  logic       r_idx;       // bank being streamed
  logic [1:0] r_sel;
  logic       start;
  logic       pop;
  logic       push;
  logic       ren;
  logic       pend;        // read issued last cycle
  logic [2:0] inflight;
  beat_t      skid_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] cnt;

  assign r_sel = r_idx ? 2'b10 : 2'b01;
  assign start = (r_state == R_IDLE) && i_done_write[r_idx];

  always_comb begin
    r_state_next = r_state;
    unique case (r_state)
      R_IDLE:   if (start) r_state_next = R_READ;
      R_READ:   if (pop && o_m_tlast) r_state_next = R_SWITCH;
      R_SWITCH: r_state_next = R_IDLE;
      default:  r_state_next = R_IDLE;
    endcase
  end

  assign o_m_tvalid = (r_state == R_READ) && (cnt != 2'd0);
  assign o_m_tdata  = skid_q[rd_ptr];
  assign pop        = o_m_tvalid && i_m_tready;
  assign push       = pend && (r_state == R_READ);

  // room left once this cycle's pop and arriving beat are counted
  assign inflight = {1'b0, cnt} + {2'b00, pend} - {2'b00, pop};
  assign ren      = (r_state == R_READ) && (inflight < 3'd2);

  assign o_bank_ren    = ren ? r_sel : 2'b00;
  assign o_bank_rewind = (r_state == R_SWITCH) ? r_sel : 2'b00;

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state     <= R_IDLE;
      r_idx       <= 1'b0;
      o_done_read <= 2'b11;      // both banks free
      pend        <= 1'b0;
      wr_ptr      <= 1'b0;
      rd_ptr      <= 1'b0;
      cnt         <= 2'd0;
    end else begin
      r_state <= r_state_next;
      pend    <= ren;
      if (start) begin
        o_done_read <= o_done_read & ~r_sel;
      end
      if (r_state == R_SWITCH) begin
        o_done_read <= o_done_read | r_sel;
        r_idx       <= ~r_idx;
        wr_ptr      <= 1'b0;     // flush prefetched beats
        rd_ptr      <= 1'b0;
        cnt         <= 2'd0;
      end else begin
        if (push) wr_ptr <= ~wr_ptr;
        if (pop)  rd_ptr <= ~rd_ptr;
        cnt <= cnt + {1'b0, push} - {1'b0, pop};
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      skid_q[wr_ptr] <= i_rdata[r_idx];
    end
  end

  rotation_counters counters_i (
    .aclk    (aclk),
    .i_rst_n (i_rst_n),
    .i_hdr   (i_hdr[r_idx]),
    .i_load  (start),
    .i_step  (pop),
    .o_last  (o_m_tlast),
    .o_user  (o_m_tuser)
  );

endmodule

`default_nettype wire

/* weight_rot_pkg.sv */
// beat width equals output width; the header occupies the low bits of the first beat of a layer
`default_nettype none

package weight_rot_pkg;

  localparam int WORD_WIDTH = 8;
  localparam int COLS       = 4;                  // weights per beat
  localparam int BEAT_W     = WORD_WIDTH * COLS;

  localparam int ADDR_W     = 6;
  localparam int BANK_DEPTH = 2 ** ADDR_W;        // beats per bank

  localparam int KH2_W      = 2;
  localparam int KW2_W      = 2;
  localparam int KH_W       = KH2_W + 1;          // holds 2*kh2
  localparam int CIN_W      = 4;
  localparam int COLS_W     = 4;
  localparam int BLOCKS_W   = 4;

  typedef logic [BEAT_W-1:0] beat_t;

  // layer header, low bits of the header beat
  typedef struct packed {
    logic [ADDR_W-1:0]   addr_max;  // weight beats minus one
    logic [BLOCKS_W-1:0] blocks_1;
    logic [COLS_W-1:0]   cols_1;
    logic [CIN_W-1:0]    cin_1;
    logic [KH2_W-1:0]    kh2;
    logic [KW2_W-1:0]    kw2;
  } hdr_t;

  // per-beat position flags on the master stream
  typedef struct packed {
    logic [KW2_W-1:0] kw2;
    logic             is_w_first;
    logic             is_cin_last;
    logic             is_col_1_k2;
    logic             is_top_block;
    logic             is_bot_block;
  } tuser_t;

  typedef enum logic [1:0] {
    W_IDLE,
    W_GET_HDR,
    W_WRITE,
    W_SWITCH
  } w_state_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_READ,
    R_SWITCH
  } r_state_e;

endpackage

`default_nettype wire

/* weight_rotator_asserts.sv */
// master stream rules only; checks sample on rising aclk and pause while i_rst_n is low
`default_nettype none

module weight_rotator_asserts (
  input wire logic                   aclk,
  input wire logic                   i_rst_n,
  input wire logic                   o_m_tvalid,
  input wire logic                   i_m_tready,
  input wire weight_rot_pkg::beat_t  o_m_tdata,
  input wire logic                   o_m_tlast,
  input wire weight_rot_pkg::tuser_t o_m_tuser
);

  timeunit 1ns;
  timeprecision 1ps;

  // nothing to send straight out of reset
  a_quiet_after_reset: assert property (@(posedge aclk) $rose(i_rst_n) |-> !o_m_tvalid)
    else $error("o_m_tvalid high in the first cycle after reset");

  a_payload_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
      o_m_tvalid && !i_m_tready |=>
        $stable(o_m_tdata) && $stable(o_m_tlast) && $stable(o_m_tuser))
    else $error("master payload changed while stalled");

  a_valid_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
      o_m_tvalid && !i_m_tready |=> o_m_tvalid)
    else $error("o_m_tvalid dropped without a handshake");

  a_last_needs_valid: assert property (@(posedge aclk) disable iff (!i_rst_n)
      o_m_tlast |-> o_m_tvalid)
    else $error("o_m_tlast high while o_m_tvalid low");

endmodule

`default_nettype wire

/* weight_writer.sv */
// first beat of each layer is the header; a layer longer than BANK_DEPTH beats wraps the bank
`default_nettype none

module weight_writer (
  input  wire logic                           aclk,
  input  wire logic                           i_rst_n,
  input  wire logic                           i_s_tvalid,
  output logic                                o_s_tready,
  input  wire weight_rot_pkg::beat_t          i_s_tdata,
  input  wire logic                           i_s_tlast,
  input  wire logic [1:0]                     i_done_read,
  output logic [1:0]                          o_done_write,
  output weight_rot_pkg::hdr_t [1:0]          o_hdr,
  output logic [1:0]                          o_bank_wen,
  output logic [1:0]                          o_bank_clear,
  output weight_rot_pkg::beat_t               o_wdata
);

  import weight_rot_pkg::*;

  w_state_e   w_state;
  w_state_e   w_state_next;
  logic       w_idx;        // bank being filled
  logic [1:0] w_sel;
  logic       s_hs;
  logic [1:0] done_write_next;

  assign w_sel      = w_idx ? 2'b10 : 2'b01;
  assign o_s_tready = (w_state == W_GET_HDR) || (w_state == W_WRITE);
  assign s_hs       = i_s_tvalid && o_s_tready;

  always_comb begin
    w_state_next = w_state;
    unique case (w_state)
      W_IDLE:    if (i_done_read[w_idx]) w_state_next = W_GET_HDR; // wait for a free bank
      W_GET_HDR: if (s_hs) w_state_next = W_WRITE;
      W_WRITE:   if (s_hs && i_s_tlast) w_state_next = W_SWITCH;
      W_SWITCH:  w_state_next = W_IDLE;
      default:   w_state_next = W_IDLE;
    endcase
  end

  always_comb begin
    done_write_next = o_done_write;
    if (w_state == W_GET_HDR) begin
      done_write_next = done_write_next & ~w_sel;
    end
    if (w_state == W_SWITCH) begin
      done_write_next = done_write_next | w_sel;
    end
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      w_state      <= W_IDLE;
      w_idx        <= 1'b0;
      o_done_write <= 2'b00;
    end else begin
      w_state      <= w_state_next;
      o_done_write <= done_write_next;
      if (w_state == W_SWITCH) begin
        w_idx <= ~w_idx;
      end
    end
  end

  // header registers, one per bank
  always_ff @(posedge aclk) begin
    if (w_state == W_GET_HDR && s_hs) begin
      o_hdr[w_idx] <= hdr_t'(i_s_tdata[$bits(hdr_t)-1:0]);
    end
  end

  assign o_bank_clear = (w_state == W_GET_HDR) ? w_sel : 2'b00;  // pointers back to 0
  assign o_bank_wen   = (w_state == W_WRITE && s_hs) ? w_sel : 2'b00;
  assign o_wdata      = i_s_tdata;

endmodule

`default_nettype wire
